//--- src/frontend_consts.svh
// Front-end constants
// Tag width, credit budget and branch restore-wait length

`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// Width of the instruction tag carried through every stage
`define TAG_W 8

// Number of queue entries the back end grants after reset
`define QUE_CREDITS 4

// Width of the credit counter, wide enough to hold QUE_CREDITS
`define CREDIT_W 3

// Cycles spent waiting for the checkpoint restore to settle
`define RESTORE_CYCLES 3

`endif

//--- src/pipe_pkg.sv
// Pipeline payload types
// Opcode enum and tag type shared by the front-end stages and the testbench

package pipe_pkg;

	`include "frontend_consts.svh"

	// ====================
	// Opcodes
	// ====================

	// Only the classes that matter to the squash logic are modelled
	// A bsr in decode squashes the slot behind it
	typedef enum logic [2:0] {
		op_nop,
		op_alu,
		op_branch,
		op_bsr,
		op_ucode
	} opcode_t;

	// Tag that identifies an item from fetch to queue
	typedef logic [`TAG_W-1:0] tag_t;

endpackage

//--- src/branch_pkg.sv
// Branch recovery types
// State enum for the checkpoint restore sequence

package branch_pkg;

	// The order is significant
	// Everything from bs_chkpt_restore up to bs_done2 counts as recovery,
	// and the squash logic tests that as a range
	typedef enum logic [2:0] {
		bs_idle,
		bs_chkpt_restore,
		bs_restore_wait,
		bs_done1,
		bs_done2
	} branch_state_t;

	// Values 5 to 7 are never entered

endpackage

//--- src/edge_det.sv
// Clock-enabled edge detector
// Rising, falling and either-edge outputs against the last enabled sample

`timescale 1ns/1ps

module edge_det (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic i,
	output logic pe,
	output logic ne,
	output logic ee
);

	// Previous value of i, only refreshed on enabled cycles
	logic prev;

	always_ff @(posedge clk) begin
		if (rst)
			prev <= 1'b0;
		else if (ce)
			prev <= i;
	end

	// The edge outputs stay up for as long as ce is low,
	// so a stalled consumer still sees the edge on its next enabled cycle
	assign pe = i & ~prev;
	assign ne = ~i & prev;
	assign ee = i ^ prev;

endmodule

//--- src/branch_recovery.sv
// Branch miss recovery FSM
// Steps through checkpoint restore, a timed wait and two done cycles

`timescale 1ns/1ps

`include "frontend_consts.svh"

module branch_recovery (
	input  logic clk,
	input  logic rst,
	input  logic branchmiss,
	output branch_pkg::branch_state_t branch_state,
	output logic branch_busy
);

	import branch_pkg::*;

	// Counter for the restore-wait state
	localparam int WAIT_W = $clog2(`RESTORE_CYCLES + 1);

	logic [WAIT_W-1:0] wait_cnt;

	// ====================
	// Recovery sequence
	// ====================

	// A miss always restarts at the checkpoint restore, even mid-sequence,
	// because the newer miss has an older checkpoint to go back to
	always_ff @(posedge clk) begin
		if (rst) begin
			branch_state <= bs_idle;
			wait_cnt <= '0;
		end else if (branchmiss) begin
			branch_state <= bs_chkpt_restore;
			wait_cnt <= '0;
		end else begin
			case (branch_state)
				bs_chkpt_restore: begin
					branch_state <= bs_restore_wait;
					wait_cnt <= '0;
				end
				// Hold here for RESTORE_CYCLES cycles
				bs_restore_wait: begin
					if (wait_cnt == WAIT_W'(`RESTORE_CYCLES - 1))
						branch_state <= bs_done1;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				bs_done1:
					branch_state <= bs_done2;
				bs_done2:
					branch_state <= bs_idle;
				default:
					branch_state <= bs_idle;
			endcase
		end
	end

	// Busy over the whole recovery range
	assign branch_busy = (branch_state >= bs_chkpt_restore) && (branch_state <= bs_done2);

endmodule

//--- src/stomp_ctrl.sv
// Squash waterfall for the five-stage front end
// Derives the per-stage stomp signals from branch misses, recovery,
// bsr decode and micro-code activity

`timescale 1ns/1ps

module stomp_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic advance_pipeline,
	input  logic micro_code_active,
	input  logic branchmiss,
	input  branch_pkg::branch_state_t branch_state,
	input  logic do_bsr,
	output logic stomp_fet,
	output logic stomp_mux,
	output logic stomp_dec,
	output logic stomp_ren,
	output logic stomp_que,
	output logic stomp_quem
);

	import branch_pkg::*;

	// Squash request for the whole pipeline
	logic stomp_pipeline;
	// First enabled cycle of that request
	logic pe_stomp_pipeline;

	// Registered part of each stage stomp
	logic stomp_mux_r;
	logic stomp_dec_r;
	logic stomp_ren_r;
	logic stomp_quem_r;

	// Values loaded into the registers on the next advance
	logic next_stomp_mux;
	logic next_stomp_dec;
	logic next_stomp_ren;
	logic next_stomp_quem;

	// ====================
	// Squash source
	// ====================

	// A miss squashes in the same cycle it is reported
	// Recovery keeps squashing until the sequence reaches idle again
	assign stomp_pipeline = branchmiss
		|| ((branch_state >= bs_chkpt_restore) && (branch_state <= bs_done2));

	// The edge sample only moves on an advance
	// A squash that starts during a stall is still seen as new when the pipe moves
	edge_det u_sq_edge (
		.clk (clk),
		.rst (rst),
		.ce  (advance_pipeline),
		.i   (stomp_pipeline),
		.pe  (pe_stomp_pipeline),
		.ne  (),
		.ee  ()
	);

	// ====================
	// Waterfall
	// ====================

	// Fetch is squashed directly and never registered
	assign stomp_fet = stomp_pipeline;

	// Each stage inherits the stomp of the stage above it
	// Micro-code freezes the waterfall, so nothing trickles down while it runs
	// The fetch stomp is the squash source itself
	// Mux therefore follows the squash source whether micro-code runs or not
	// A bsr leaving decode kills the slot behind it in mux
	assign next_stomp_mux  = stomp_pipeline || do_bsr;
	assign next_stomp_dec  = (stomp_mux && !micro_code_active) || stomp_pipeline;
	assign next_stomp_ren  = (stomp_dec && !micro_code_active) || stomp_pipeline;
	assign next_stomp_quem = (stomp_ren && !micro_code_active) || stomp_pipeline;

	// Everything comes out of reset squashed
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_mux_r  <= 1'b1;
			stomp_dec_r  <= 1'b1;
			stomp_ren_r  <= 1'b1;
			stomp_quem_r <= 1'b1;
			stomp_que    <= 1'b1;
		end else if (advance_pipeline) begin
			stomp_mux_r  <= next_stomp_mux;
			stomp_dec_r  <= next_stomp_dec;
			stomp_ren_r  <= next_stomp_ren;
			stomp_quem_r <= next_stomp_quem;
			// Queue items that were already dead at rename
			stomp_que    <= stomp_ren;
		end
	end

	// On the first advance of a squash all later stages are hit together,
	// otherwise the items already past fetch would slip through
	assign stomp_mux  = pe_stomp_pipeline || stomp_mux_r;
	assign stomp_dec  = pe_stomp_pipeline || stomp_dec_r;
	assign stomp_ren  = pe_stomp_pipeline || stomp_ren_r;
	// Queue cannot drop items after rename
	// It turns them into copy targets instead
	assign stomp_quem = pe_stomp_pipeline || stomp_quem_r;

	// The recovery range test above only works on the five legal state codes
	a_state_legal : assert property (@(posedge clk) disable iff (rst)
		branch_state <= bs_done2)
		else $error("branch_state holds a code outside the recovery sequence");

endmodule

//--- src/frontend_pipe.sv
// Five-stage front-end pipeline
// Stage registers for fetch, mux, decode, rename and queue,
// squash drop and copy marking, bsr detection and the queue credit counter

`timescale 1ns/1ps

`include "frontend_consts.svh"

module frontend_pipe (
	input  logic clk,
	input  logic rst,
	input  logic fetch_valid,
	input  pipe_pkg::opcode_t fetch_opcode,
	input  pipe_pkg::tag_t fetch_tag,
	input  logic credit_return,
	input  logic stomp_fet,
	input  logic stomp_mux,
	input  logic stomp_dec,
	input  logic stomp_ren,
	input  logic stomp_que,
	input  logic stomp_quem,
	output logic advance_pipeline,
	output logic do_bsr,
	output logic out_valid,
	output pipe_pkg::opcode_t out_opcode,
	output pipe_pkg::tag_t out_tag,
	output logic out_copy
);

	import pipe_pkg::*;

	// Stage indices, fetch at the top and queue at the bottom
	localparam int NSTG = 5;
	localparam int FET = 0;
	localparam int DEC = 2;
	localparam int QUE = NSTG - 1;

	// Per-stage valid bits and payload
	logic [NSTG-1:0] stg_v;
	opcode_t stg_op [NSTG];
	tag_t stg_tag [NSTG];

	// Stomp applied to the item leaving stage i
	logic [NSTG-2:0] stomp_leave;

	// Queue entries still granted by the back end
	logic [`CREDIT_W-1:0] credit_cnt;

	// ====================
	// Flow control
	// ====================

	// The whole pipe moves as one while any credit remains
	assign advance_pipeline = (credit_cnt != '0);

	// The queue item leaves on an advance and takes one credit with it
	// A held item is not shown as valid, so it is emitted exactly once
	assign out_valid = stg_v[QUE] & advance_pipeline;

	always_ff @(posedge clk) begin
		if (rst)
			credit_cnt <= `CREDIT_W'(`QUE_CREDITS);
		else
			credit_cnt <= credit_cnt + `CREDIT_W'(credit_return) - `CREDIT_W'(out_valid);
	end

	// ====================
	// Stage registers
	// ====================

	assign stomp_leave = {stomp_ren, stomp_dec, stomp_mux, stomp_fet};

	// Valid bits are cleared by the stomp of the stage the item leaves
	// Fetch is only sampled on an advance, otherwise every stage holds
	always_ff @(posedge clk) begin
		if (rst) begin
			stg_v <= '0;
		end else if (advance_pipeline) begin
			stg_v[FET] <= fetch_valid;
			for (int i = 1; i < NSTG; i++)
				stg_v[i] <= stg_v[i-1] & ~stomp_leave[i-1];
		end
	end

	// Payload just shifts along, the valid bit decides if it means anything
	always_ff @(posedge clk) begin
		if (advance_pipeline) begin
			stg_op[FET] <= fetch_opcode;
			stg_tag[FET] <= fetch_tag;
			for (int i = 1; i < NSTG; i++) begin
				stg_op[i] <= stg_op[i-1];
				stg_tag[i] <= stg_tag[i-1];
			end
		end
	end

	// A subroutine call sitting in decode
	assign do_bsr = stg_v[DEC] && (stg_op[DEC] == op_bsr);

	// ====================
	// Queue output
	// ====================

	assign out_opcode = stg_op[QUE];
	assign out_tag = stg_tag[QUE];

	// Items squashed at queue have been renamed already
	// They still go out but only as copy targets
	assign out_copy = out_valid & (stomp_quem | stomp_que);

	// Back end never hands back more credits than it was given
	a_credit_max : assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= `CREDIT_W'(`QUE_CREDITS))
		else $error("credit count above the queue budget");

endmodule

//--- src/frontend_top.sv
// Front-end top level
// Connects the stage pipeline, the squash waterfall and branch recovery

`timescale 1ns/1ps

module frontend_top (
	input  logic clk,
	input  logic rst,
	input  logic fetch_valid,
	input  pipe_pkg::opcode_t fetch_opcode,
	input  pipe_pkg::tag_t fetch_tag,
	input  logic micro_code_active,
	input  logic branchmiss,
	input  logic credit_return,
	output logic out_valid,
	output pipe_pkg::opcode_t out_opcode,
	output pipe_pkg::tag_t out_tag,
	output logic out_copy,
	output logic branch_busy
);

	import branch_pkg::*;

	// Pipeline status toward the squash logic
	logic advance_pipeline;
	logic do_bsr;
	branch_state_t branch_state;

	// Per-stage squash signals back into the pipeline
	logic stomp_fet;
	logic stomp_mux;
	logic stomp_dec;
	logic stomp_ren;
	logic stomp_que;
	logic stomp_quem;

	frontend_pipe u_pipe (
		.clk              (clk),
		.rst              (rst),
		.fetch_valid      (fetch_valid),
		.fetch_opcode     (fetch_opcode),
		.fetch_tag        (fetch_tag),
		.credit_return    (credit_return),
		.stomp_fet        (stomp_fet),
		.stomp_mux        (stomp_mux),
		.stomp_dec        (stomp_dec),
		.stomp_ren        (stomp_ren),
		.stomp_que        (stomp_que),
		.stomp_quem       (stomp_quem),
		.advance_pipeline (advance_pipeline),
		.do_bsr           (do_bsr),
		.out_valid        (out_valid),
		.out_opcode       (out_opcode),
		.out_tag          (out_tag),
		.out_copy         (out_copy)
	);

	// Squash waterfall
	stomp_ctrl u_stomp (
		.clk               (clk),
		.rst               (rst),
		.advance_pipeline  (advance_pipeline),
		.micro_code_active (micro_code_active),
		.branchmiss        (branchmiss),
		.branch_state      (branch_state),
		.do_bsr            (do_bsr),
		.stomp_fet         (stomp_fet),
		.stomp_mux         (stomp_mux),
		.stomp_dec         (stomp_dec),
		.stomp_ren         (stomp_ren),
		.stomp_que         (stomp_que),
		.stomp_quem        (stomp_quem)
	);

	branch_recovery u_brec (
		.clk          (clk),
		.rst          (rst),
		.branchmiss   (branchmiss),
		.branch_state (branch_state),
		.branch_busy  (branch_busy)
	);

endmodule

//--- bench/frontend_checker.sv
// Output checker for the front end
// Compares emitted items with the expected list, tracks credits in flight
// and measures the length of each branch recovery

`timescale 1ns/1ps

`include "frontend_consts.svh"

module frontend_checker (
	input  logic clk,
	input  logic rst,
	input  logic out_valid,
	input  pipe_pkg::opcode_t out_opcode,
	input  pipe_pkg::tag_t out_tag,
	input  logic out_copy,
	input  logic credit_return,
	input  logic branch_busy
);

	import pipe_pkg::*;

	localparam STIM_FILE = "bench/frontend_stim.txt";

	int n_expected;
	int n_seen;
	int n_cmp_errors;
	int n_proto_errors;
	int n_recoveries;

	// Expected items in emission order
	tag_t exp_tag[$];
	opcode_t exp_op[$];
	logic exp_copy[$];
	logic [8*16-1:0] exp_name[$];

	int in_flight;
	int busy_len;

	// ====================
	// Expected list
	// ====================

	// Each "e" line expands to count items with rising tags
	initial begin : load_expected
		int lfd;
		int code;
		int n;
		int v_tag;
		int v_op;
		int v_copy;
		logic [8*16-1:0] tok;
		logic [8*16-1:0] name;
		logic [8*256-1:0] rest;
		n_expected = 0;
		n_seen = 0;
		n_cmp_errors = 0;
		n_proto_errors = 0;
		n_recoveries = 0;
		in_flight = 0;
		busy_len = 0;
		lfd = $fopen(STIM_FILE, "r");
		if (lfd == 0) begin
			$display("Checker could not open the stimulus file %s", STIM_FILE);
			n_proto_errors++;
		end else begin
			code = $fscanf(lfd, "%s", tok);
			while (code == 1) begin
				if (tok == "e") begin
					code = $fscanf(lfd, "%d %h %d %d %s", n, v_tag, v_op, v_copy, name);
					if (code == 5) begin
						for (int j = 0; j < n; j++) begin
							exp_tag.push_back(tag_t'(v_tag + j));
							exp_op.push_back(opcode_t'(v_op));
							exp_copy.push_back(v_copy != 0);
							exp_name.push_back(name);
						end
					end else begin
						$display("An expected line in the stimulus file could not be read");
						n_proto_errors++;
					end
				end else begin
					code = $fgets(rest, lfd);
					code = 5;
				end
				if (code == 5)
					code = $fscanf(lfd, "%s", tok);
				else
					code = -1;
			end
			$fclose(lfd);
			n_expected = exp_tag.size();
		end
	end

	// ====================
	// Item compare
	// ====================

	always @(posedge clk) begin
		if (!rst && out_valid) begin
			if (n_seen >= n_expected) begin
				$display("An item with tag %h came out after the expected list was used up", out_tag);
				n_proto_errors++;
			end else if (out_tag !== exp_tag[n_seen] || out_opcode !== exp_op[n_seen]
					|| out_copy !== exp_copy[n_seen]) begin
				$display("Error %0s: expected tag %h op %0d copy %0b, actual tag %h op %0d copy %0b",
					exp_name[n_seen], exp_tag[n_seen], exp_op[n_seen], exp_copy[n_seen],
					out_tag, out_opcode, out_copy);
				n_cmp_errors++;
			end
			n_seen++;
		end
	end

	// Items out minus credits back may never pass the queue budget
	always @(posedge clk) begin
		if (!rst) begin
			if (out_valid && in_flight >= `QUE_CREDITS) begin
				$display("An item was emitted although every credit was in use");
				n_proto_errors++;
			end
			in_flight = in_flight + int'(out_valid) - int'(credit_return);
		end
	end

	// Every recovery lasts restore wait plus three cycles
	always @(posedge clk) begin
		if (!rst) begin
			if (branch_busy) begin
				busy_len++;
			end else if (busy_len > 0) begin
				if (busy_len != `RESTORE_CYCLES + 3) begin
					$display("Error recovery_length: expected %0d, actual %0d",
						`RESTORE_CYCLES + 3, busy_len);
					n_cmp_errors++;
				end
				n_recoveries++;
				busy_len = 0;
			end
		end
	end

endmodule

//--- bench/tb_frontend.sv
// Front-end testbench top
// Clock, reset, per-cycle stimulus from the stim file and the back-end credit return

`timescale 1ns/1ps

`include "frontend_consts.svh"

module tb_frontend;

	import pipe_pkg::*;

	localparam STIM_FILE = "bench/frontend_stim.txt";
	localparam int ITEM_TIMEOUT = 400;
	localparam int RETURN_TIMEOUT = 50;

	logic clk;
	logic rst;
	logic fetch_valid;
	opcode_t fetch_opcode;
	tag_t fetch_tag;
	logic micro_code_active;
	logic branchmiss;
	logic credit_return;
	logic out_valid;
	opcode_t out_opcode;
	tag_t out_tag;
	logic out_copy;
	logic branch_busy;

	integer seed;
	int cyc;
	int fd;
	int n_tb_errors;
	int n_miss;
	// Credit count the DUT should hold in the current cycle
	int credits;
	// Cycle numbers at which the back end hands a credit back
	int ret_due[$];
	// Fetch items waiting for a cycle with credits
	opcode_t pend_op[$];
	tag_t pend_tag[$];

	initial clk = 1'b0;
	always #50 clk = ~clk;

	frontend_top i_dut (
		.clk               (clk),
		.rst               (rst),
		.fetch_valid       (fetch_valid),
		.fetch_opcode      (fetch_opcode),
		.fetch_tag         (fetch_tag),
		.micro_code_active (micro_code_active),
		.branchmiss        (branchmiss),
		.credit_return     (credit_return),
		.out_valid         (out_valid),
		.out_opcode        (out_opcode),
		.out_tag           (out_tag),
		.out_copy          (out_copy),
		.branch_busy       (branch_busy)
	);

	frontend_checker i_chk (
		.clk           (clk),
		.rst           (rst),
		.out_valid     (out_valid),
		.out_opcode    (out_opcode),
		.out_tag       (out_tag),
		.out_copy      (out_copy),
		.credit_return (credit_return),
		.branch_busy   (branch_busy)
	);

	// ====================
	// Per-cycle driver
	// ====================

	// Waits for the next edge and drives the inputs of the cycle that starts there
	task automatic step_cycle(input logic mc, input logic bm, input logic hold_ret);
		int d;
		logic ret;
		@(posedge clk);
		cyc++;
		// Outputs read here still belong to the cycle that just ended
		credits = credits + int'(credit_return) - int'(out_valid);
		if (out_valid) begin
			d = 1 + int'($unsigned($random(seed)) % 3);
			ret_due.push_back(cyc - 1 + d);
		end
		// One credit per pulse, so returns that fall together go out one after another
		ret = 1'b0;
		if (!hold_ret && ret_due.size() > 0 && ret_due[0] <= cyc) begin
			ret = 1'b1;
			void'(ret_due.pop_front());
		end
		credit_return <= ret;
		micro_code_active <= mc;
		branchmiss <= bm;
		// An item is only shown when the pipe is sure to take it
		if (credits > 0 && pend_tag.size() > 0) begin
			fetch_valid <= 1'b1;
			fetch_opcode <= pend_op.pop_front();
			fetch_tag <= pend_tag.pop_front();
		end else begin
			fetch_valid <= 1'b0;
		end
	endtask

	// Next "v" line of the stim file; other lines are skipped
	task automatic read_vector(output logic ok, output int n, output int v [6]);
		logic [8*16-1:0] tok;
		logic [8*256-1:0] rest;
		int code;
		ok = 1'b0;
		n = 0;
		code = $fscanf(fd, "%s", tok);
		while (code == 1 && !ok) begin
			if (tok == "v") begin
				code = $fscanf(fd, "%d %d %d %h %d %d %d", n, v[0], v[1], v[2], v[3], v[4], v[5]);
				if (code == 7) begin
					ok = 1'b1;
				end else begin
					$display("A vector line in the stimulus file could not be read");
					n_tb_errors++;
					code = -1;
				end
			end else begin
				code = $fgets(rest, fd);
				code = $fscanf(fd, "%s", tok);
			end
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		logic ok;
		int n;
		int v [6];
		int waited;
		int total;
		seed = 22;
		cyc = 0;
		n_tb_errors = 0;
		n_miss = 0;
		credits = `QUE_CREDITS;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_opcode = op_nop;
		fetch_tag = '0;
		micro_code_active = 1'b0;
		branchmiss = 1'b0;
		credit_return = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			n_tb_errors++;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		if (fd != 0) begin
			read_vector(ok, n, v);
			while (ok) begin
				// Columns: fetch_valid, opcode, first tag, micro-code, branchmiss, hold
				for (int j = 0; j < n; j++) begin
					if (v[0] != 0) begin
						pend_op.push_back(opcode_t'(v[1]));
						pend_tag.push_back(tag_t'(v[2] + j));
					end
					if (v[4] != 0 && j == 0)
						n_miss++;
					step_cycle(v[3] != 0, v[4] != 0 && j == 0, v[5] != 0);
				end
				read_vector(ok, n, v);
			end
			$fclose(fd);
		end

		waited = 0;
		while (i_chk.n_seen < i_chk.n_expected && waited < ITEM_TIMEOUT) begin
			step_cycle(1'b0, 1'b0, 1'b0);
			waited++;
		end
		if (i_chk.n_seen < i_chk.n_expected) begin
			$display("Timed out waiting for %0d items, only %0d came out",
				i_chk.n_expected, i_chk.n_seen);
			n_tb_errors++;
		end

		waited = 0;
		while (ret_due.size() > 0 && waited < RETURN_TIMEOUT) begin
			step_cycle(1'b0, 1'b0, 1'b0);
			waited++;
		end
		if (ret_due.size() > 0) begin
			$display("Timed out waiting for the back end to hand back its credits");
			n_tb_errors++;
		end

		// Quiet stretch in which no stray item may appear
		repeat (10) step_cycle(1'b0, 1'b0, 1'b0);

		if (i_chk.n_expected == 0) begin
			$display("The stimulus file holds no expected items");
			n_tb_errors++;
		end
		if (i_chk.n_recoveries != n_miss) begin
			$display("Error recovery_count: expected %0d, actual %0d", n_miss, i_chk.n_recoveries);
			n_tb_errors++;
		end

		total = i_chk.n_cmp_errors + i_chk.n_proto_errors + n_tb_errors;
		$display("Errors: %0d compare, %0d protocol, %0d bench",
			i_chk.n_cmp_errors, i_chk.n_proto_errors, n_tb_errors);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- bench/frontend_stim.txt
# v count fetch_valid opcode tag_hex micro_code branchmiss hold_credits   (tag rises per cycle)
# e count tag_hex opcode copy test_name   (tag rises per item)  opcodes 0 nop 1 alu 2 branch 3 bsr
v 8 0 0 00 0 0 0
# plain flow
v 5 1 1 01 0 0 0
v 8 0 0 00 0 0 0
# branch miss with the pipe full
v 5 1 1 10 0 0 0
v 1 1 2 15 0 1 0
v 8 1 1 16 0 0 0
v 10 0 0 00 0 0 0
# subroutine call
v 1 1 1 20 0 0 0
v 1 1 3 21 0 0 0
v 3 1 1 22 0 0 0
v 10 0 0 00 0 0 0
# branch miss while micro-code runs
v 5 1 1 30 1 0 0
v 1 1 1 35 1 1 0
v 8 1 1 36 1 0 0
v 6 0 0 00 1 0 0
v 10 0 0 00 0 0 0
# credits held back then released
v 10 1 1 40 0 0 1
v 6 0 0 00 0 0 1
v 12 0 0 00 0 0 0
# expected output
e 5 01 1 0 plain_flow
e 1 10 1 1 branch_miss
e 3 1b 1 0 branch_miss
e 1 20 1 0 subroutine_call
e 1 21 3 0 subroutine_call
e 1 22 1 0 subroutine_call
e 1 24 1 0 subroutine_call
e 1 30 1 1 micro_code
e 3 3b 1 0 micro_code
e 10 40 1 0 credits

//--- frontend_top.f
+incdir+src
src/pipe_pkg.sv
src/branch_pkg.sv
src/edge_det.sv
src/branch_recovery.sv
src/stomp_ctrl.sv
src/frontend_pipe.sv
src/frontend_top.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend_top

sources:
  - include_dirs:
      - src
    files:
      - src/pipe_pkg.sv
      - src/branch_pkg.sv
      - src/edge_det.sv
      - src/branch_recovery.sv
      - src/stomp_ctrl.sv
      - src/frontend_pipe.sv
      - src/frontend_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/frontend_checker.sv
      - bench/tb_frontend.sv
